// ==== common/router_stats_params.svh ====
//////////////////////////////
// Register map is in word addresses. Snapshot words per port follow the
// order pkt, byte, err, drop
//////////////////////////////

`ifndef ROUTER_STATS_PARAMS_SVH
`define ROUTER_STATS_PARAMS_SVH

// Sizes
`define ROUTER_NUM_PORTS        8
`define ROUTER_CNT_WIDTH        32
`define ROUTER_REG_ADDR_WIDTH   7
`define ROUTER_CNTRS_PER_PORT   4

// Register map
`define ROUTER_ADDR_ING_PORT_ENABLE_CON     0
`define ROUTER_ADDR_EGR_PORT_ENABLE_CON     1
`define ROUTER_ADDR_ING_PORT_ENABLE_STAT    2
`define ROUTER_ADDR_EGR_PORT_ENABLE_STAT    3
`define ROUTER_ADDR_ING_COUNTER_CON         4
`define ROUTER_ADDR_EGR_COUNTER_CON         5
`define ROUTER_ADDR_ING_COUNTERS_START      6
`define ROUTER_ADDR_EGR_COUNTERS_START      38
`define ROUTER_TOTAL_REGS                   70

`endif

// ==== common/router_stats_pkg.sv ====
//////////////////////////////
// Struct field order fixes the bit layout seen by the testbench
//////////////////////////////

`default_nettype none

`include "router_stats_params.svh"

package router_stats_pkg;

    // Live traffic counts of one port
    typedef struct packed {
        logic [`ROUTER_CNT_WIDTH-1:0] pkt_cnt;
        logic [`ROUTER_CNT_WIDTH-1:0] byte_cnt;
        logic [`ROUTER_CNT_WIDTH-1:0] err_cnt;
    } port_stats_t;

    // Captured counts read at word offsets 0 to 3
    typedef struct packed {
        port_stats_t                  stats;
        logic [`ROUTER_CNT_WIDTH-1:0] drop_cnt;
    } port_snapshot_t;

    // Register bus request with single-cycle read and write strobes
    typedef struct packed {
        logic                              read;
        logic                              write;
        logic [`ROUTER_REG_ADDR_WIDTH-1:0] addr;
        logic [`ROUTER_CNT_WIDTH-1:0]      wdata;
    } reg_req_t;

    typedef struct packed {
        logic                         rvalid;
        logic                         error;
        logic [`ROUTER_CNT_WIDTH-1:0] rdata;
    } reg_rsp_t;

endpackage

`default_nettype wire

// ==== hw/drop_event_counter.sv ====
//////////////////////////////
// Counts rising edges only. A sample restarts the count, at one when an
// edge lands in the same cycle
//////////////////////////////

`default_nettype none

`include "router_stats_params.svh"

module drop_event_counter (
    input  logic                         core_clk_ifc,
    input  logic                         peripheral_sresetn_core,
    input  logic [`ROUTER_NUM_PORTS-1:0] buf_full_drop,
    input  logic [`ROUTER_NUM_PORTS-1:0] sample,
    output logic [`ROUTER_CNT_WIDTH-1:0] drop_cnts [`ROUTER_NUM_PORTS]
);

    logic [`ROUTER_NUM_PORTS-1:0] drop_d;
    logic [`ROUTER_NUM_PORTS-1:0] drop_edge;

    // Flag high now, low one cycle before
    assign drop_edge = buf_full_drop & ~drop_d;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            drop_d <= '0;
            for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                drop_cnts[p] <= '0;
            end
        end else begin
            drop_d <= buf_full_drop;
            for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                if (sample[p]) begin
                    drop_cnts[p] <= {{(`ROUTER_CNT_WIDTH-1){1'b0}}, drop_edge[p]};
                end else if (drop_edge[p]) begin
                    drop_cnts[p] <= drop_cnts[p] + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // An edge outside a sample must never wrap the count to zero
    for (genvar p = 0; p < `ROUTER_NUM_PORTS; p++) begin : g_wrap_chk
        a_no_wrap: assert property (@(posedge core_clk_ifc)
            disable iff (!peripheral_sresetn_core)
            drop_edge[p] && !sample[p] |=> drop_cnts[p] != '0);
    end

endmodule

`default_nettype wire

// ==== hw/router_stats_top.sv ====
//////////////////////////////
// Single core clock. Ingress and egress each get a drop counter and a
// snapshot file, both read through one decoder
//////////////////////////////

`default_nettype none

`include "router_stats_params.svh"

module router_stats_top
    import router_stats_pkg::*;
(
    input  logic                         core_clk_ifc,
    input  logic                         peripheral_sresetn_core,
    input  reg_req_t                     reg_req,
    output reg_rsp_t                     reg_rsp,
    input  port_stats_t                  ing_traffic_cnts [`ROUTER_NUM_PORTS],
    input  port_stats_t                  egr_traffic_cnts [`ROUTER_NUM_PORTS],
    input  logic [`ROUTER_NUM_PORTS-1:0] ing_buf_full_drop,
    input  logic [`ROUTER_NUM_PORTS-1:0] egr_buf_full_drop,
    output logic [`ROUTER_NUM_PORTS-1:0] ing_port_enable,
    output logic [`ROUTER_NUM_PORTS-1:0] egr_port_enable
);

    logic [`ROUTER_NUM_PORTS-1:0] ing_sample;
    logic [`ROUTER_NUM_PORTS-1:0] egr_sample;
    logic [`ROUTER_CNT_WIDTH-1:0] ing_drop_cnts [`ROUTER_NUM_PORTS];
    logic [`ROUTER_CNT_WIDTH-1:0] egr_drop_cnts [`ROUTER_NUM_PORTS];
    port_snapshot_t               ing_snapshots [`ROUTER_NUM_PORTS];
    port_snapshot_t               egr_snapshots [`ROUTER_NUM_PORTS];

    stats_reg_decoder u_stats_reg_decoder (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .reg_req                 ( reg_req                 ),
        .reg_rsp                 ( reg_rsp                 ),
        .ing_snapshots           ( ing_snapshots           ),
        .egr_snapshots           ( egr_snapshots           ),
        .ing_port_enable         ( ing_port_enable         ),
        .egr_port_enable         ( egr_port_enable         ),
        .ing_sample              ( ing_sample              ),
        .egr_sample              ( egr_sample              )
    );

    //////////////////////////////
    // Ingress
    //////////////////////////////

    drop_event_counter u_ing_drop_event_counter (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .buf_full_drop           ( ing_buf_full_drop       ),
        .sample                  ( ing_sample              ),
        .drop_cnts               ( ing_drop_cnts           )
    );

    stats_snapshot u_ing_stats_snapshot (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample                  ( ing_sample              ),
        .traffic_cnts            ( ing_traffic_cnts        ),
        .drop_cnts               ( ing_drop_cnts           ),
        .snapshots               ( ing_snapshots           )
    );

    //////////////////////////////
    // Egress
    //////////////////////////////

    drop_event_counter u_egr_drop_event_counter (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .buf_full_drop           ( egr_buf_full_drop       ),
        .sample                  ( egr_sample              ),
        .drop_cnts               ( egr_drop_cnts           )
    );

    stats_snapshot u_egr_stats_snapshot (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample                  ( egr_sample              ),
        .traffic_cnts            ( egr_traffic_cnts        ),
        .drop_cnts               ( egr_drop_cnts           ),
        .snapshots               ( egr_snapshots           )
    );

endmodule

`default_nettype wire

// ==== hw/stats_reg_decoder.sv ====
//////////////////////////////
// Word-addressed register bus, no back-pressure. Read data returns one
// cycle after the strobe, addresses past the map give an error
//////////////////////////////

`default_nettype none

`include "router_stats_params.svh"

module stats_reg_decoder
    import router_stats_pkg::*;
(
    input  logic                         core_clk_ifc,
    input  logic                         peripheral_sresetn_core,
    input  reg_req_t                     reg_req,
    output reg_rsp_t                     reg_rsp,
    input  port_snapshot_t               ing_snapshots [`ROUTER_NUM_PORTS],
    input  port_snapshot_t               egr_snapshots [`ROUTER_NUM_PORTS],
    output logic [`ROUTER_NUM_PORTS-1:0] ing_port_enable,
    output logic [`ROUTER_NUM_PORTS-1:0] egr_port_enable,
    output logic [`ROUTER_NUM_PORTS-1:0] ing_sample,
    output logic [`ROUTER_NUM_PORTS-1:0] egr_sample
);

    localparam int SEL_W  = $clog2(`ROUTER_CNTRS_PER_PORT);
    localparam int PORT_W = $clog2(`ROUTER_NUM_PORTS);

    logic [`ROUTER_NUM_PORTS-1:0]      ing_enable_stat;
    logic [`ROUTER_NUM_PORTS-1:0]      egr_enable_stat;
    logic [`ROUTER_NUM_PORTS-1:0]      ing_cnt_con;
    logic [`ROUTER_NUM_PORTS-1:0]      egr_cnt_con;
    logic [`ROUTER_NUM_PORTS-1:0]      ing_req_q;
    logic [`ROUTER_NUM_PORTS-1:0]      ing_req_qq;
    logic [`ROUTER_NUM_PORTS-1:0]      egr_req_q;
    logic [`ROUTER_NUM_PORTS-1:0]      egr_req_qq;
    logic [`ROUTER_REG_ADDR_WIDTH-1:0] ing_off;
    logic [`ROUTER_REG_ADDR_WIDTH-1:0] egr_off;
    logic [`ROUTER_CNT_WIDTH-1:0]      rd_data;
    logic                              rd_err;
    logic                              rsp_valid;
    logic                              rsp_error;
    logic [`ROUTER_CNT_WIDTH-1:0]      rsp_data;

    function automatic logic [`ROUTER_CNT_WIDTH-1:0] zext(input logic [`ROUTER_NUM_PORTS-1:0] v);
        return {{(`ROUTER_CNT_WIDTH-`ROUTER_NUM_PORTS){1'b0}}, v};
    endfunction

    // Word order inside a port is pkt, byte, err, drop
    function automatic logic [`ROUTER_CNT_WIDTH-1:0] snap_word(input port_snapshot_t s,
                                                               input logic [SEL_W-1:0] sel);
        case (sel)
            0:       return s.stats.pkt_cnt;
            1:       return s.stats.byte_cnt;
            2:       return s.stats.err_cnt;
            default: return s.drop_cnt;
        endcase
    endfunction

    //////////////////////////////
    // Control and sample edges
    //////////////////////////////

    // Rising bit of the delayed request copy gives a one-cycle pulse
    assign ing_sample = ing_req_q & ~ing_req_qq;
    assign egr_sample = egr_req_q & ~egr_req_qq;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_port_enable <= '1;
            egr_port_enable <= '1;
            ing_enable_stat <= '1;
            egr_enable_stat <= '1;
            ing_cnt_con     <= '0;
            egr_cnt_con     <= '0;
            ing_req_q       <= '0;
            ing_req_qq      <= '0;
            egr_req_q       <= '0;
            egr_req_qq      <= '0;
        end else begin
            ing_enable_stat <= ing_port_enable;
            egr_enable_stat <= egr_port_enable;
            ing_req_q       <= ing_cnt_con;
            ing_req_qq      <= ing_req_q;
            egr_req_q       <= egr_cnt_con;
            egr_req_qq      <= egr_req_q;
            if (reg_req.write) begin
                case (reg_req.addr)
                    `ROUTER_ADDR_ING_PORT_ENABLE_CON:
                        ing_port_enable <= reg_req.wdata[`ROUTER_NUM_PORTS-1:0];
                    `ROUTER_ADDR_EGR_PORT_ENABLE_CON:
                        egr_port_enable <= reg_req.wdata[`ROUTER_NUM_PORTS-1:0];
                    `ROUTER_ADDR_ING_COUNTER_CON:
                        ing_cnt_con <= reg_req.wdata[`ROUTER_NUM_PORTS-1:0];
                    `ROUTER_ADDR_EGR_COUNTER_CON:
                        egr_cnt_con <= reg_req.wdata[`ROUTER_NUM_PORTS-1:0];
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    assign ing_off = reg_req.addr - `ROUTER_REG_ADDR_WIDTH'(`ROUTER_ADDR_ING_COUNTERS_START);
    assign egr_off = reg_req.addr - `ROUTER_REG_ADDR_WIDTH'(`ROUTER_ADDR_EGR_COUNTERS_START);

    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        if (reg_req.addr >= `ROUTER_TOTAL_REGS) begin
            rd_err = 1'b1;
        end else if (reg_req.addr >= `ROUTER_ADDR_EGR_COUNTERS_START) begin
            rd_data = snap_word(egr_snapshots[egr_off[SEL_W +: PORT_W]], egr_off[SEL_W-1:0]);
        end else if (reg_req.addr >= `ROUTER_ADDR_ING_COUNTERS_START) begin
            rd_data = snap_word(ing_snapshots[ing_off[SEL_W +: PORT_W]], ing_off[SEL_W-1:0]);
        end else begin
            case (reg_req.addr)
                `ROUTER_ADDR_ING_PORT_ENABLE_CON:  rd_data = zext(ing_port_enable);
                `ROUTER_ADDR_EGR_PORT_ENABLE_CON:  rd_data = zext(egr_port_enable);
                `ROUTER_ADDR_ING_PORT_ENABLE_STAT: rd_data = zext(ing_enable_stat);
                `ROUTER_ADDR_EGR_PORT_ENABLE_STAT: rd_data = zext(egr_enable_stat);
                `ROUTER_ADDR_ING_COUNTER_CON:      rd_data = zext(ing_cnt_con);
                default:                           rd_data = zext(egr_cnt_con);
            endcase
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= reg_req.read;
        end
    end

    // Data and error only mean something while rvalid is high
    always_ff @(posedge core_clk_ifc) begin
        if (reg_req.read) begin
            rsp_data  <= rd_data;
            rsp_error <= rd_err;
        end
    end

    assign reg_rsp = '{rvalid: rsp_valid, error: rsp_error, rdata: rsp_data};

    a_no_rd_wr: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core)
        !(reg_req.read && reg_req.write));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module router_stats_tb -Mdir "$BUILD_DIR" \
    -f sources.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/Vrouter_stats_tb" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$SIM_LOG"; then
    echo "Simulation reported a failure, see $SIM_LOG"
    exit 1
fi

echo "Simulation finished without a reported failure"
exit 0

// ==== sources.f ====
+incdir+common
common/router_stats_pkg.sv
hw/drop_event_counter.sv
stats_snapshot/stats_snapshot.sv
hw/stats_reg_decoder.sv
hw/router_stats_top.sv
testbench/router_stats_tb.sv

// ==== stats_snapshot/stats_snapshot.sv ====
//////////////////////////////
// One snapshot per port, loaded only on that port's sample pulse
//////////////////////////////

`default_nettype none

`include "router_stats_params.svh"

module stats_snapshot
    import router_stats_pkg::*;
(
    input  logic                         core_clk_ifc,
    input  logic                         peripheral_sresetn_core,
    input  logic [`ROUTER_NUM_PORTS-1:0] sample,
    input  port_stats_t                  traffic_cnts [`ROUTER_NUM_PORTS],
    input  logic [`ROUTER_CNT_WIDTH-1:0] drop_cnts [`ROUTER_NUM_PORTS],
    output port_snapshot_t               snapshots [`ROUTER_NUM_PORTS]
);

    //////////////////////////////
    // Capture
    //////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                snapshots[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                // Traffic and drop counts land together so software sees
                // one consistent view of the port
                if (sample[p]) begin
                    snapshots[p].stats    <= traffic_cnts[p];
                    snapshots[p].drop_cnt <= drop_cnts[p];
                end
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    for (genvar p = 0; p < `ROUTER_NUM_PORTS; p++) begin : g_hold_chk
        // Without a sample the port's words hold across the next edge
        a_hold: assert property (@(posedge core_clk_ifc)
            disable iff (!peripheral_sresetn_core)
            !sample[p] |=> $stable(snapshots[p]));
    end

endmodule

`default_nettype wire

// ==== testbench/router_stats_tb.sv ====
//////////////////////////////
// Directed tests over the register bus. Expected values come from a model
// of the register map and the sample timing
//////////////////////////////

`default_nettype none

`include "router_stats_params.svh"

module router_stats_tb
    import router_stats_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NP        = `ROUTER_NUM_PORTS;
    localparam int          WPP       = `ROUTER_CNTRS_PER_PORT;
    localparam int          RD_LIMIT  = 20;
    localparam logic [31:0] PORT_MASK = (32'd1 << NP) - 32'd1;

    logic          core_clk_ifc;
    logic          peripheral_sresetn_core;
    reg_req_t      reg_req;
    reg_rsp_t      reg_rsp;
    port_stats_t   ing_traffic_cnts [NP];
    port_stats_t   egr_traffic_cnts [NP];
    logic [NP-1:0] ing_buf_full_drop;
    logic [NP-1:0] egr_buf_full_drop;
    logic [NP-1:0] ing_port_enable;
    logic [NP-1:0] egr_port_enable;

    // Model state with index 0 for ingress and 1 for egress
    port_stats_t   live_cnts [2][NP];
    port_stats_t   snap_exp [2][NP];
    logic [31:0]   drop_pend [2][NP];
    logic [31:0]   drop_exp [2][NP];
    logic [NP-1:0] en_exp [2];
    logic [31:0]   lcg_state;
    int            check_cnt;
    int            value_errs;
    int            timeout_errs;

    router_stats_top u_router_stats_top (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .reg_req                 ( reg_req                 ),
        .reg_rsp                 ( reg_rsp                 ),
        .ing_traffic_cnts        ( ing_traffic_cnts        ),
        .egr_traffic_cnts        ( egr_traffic_cnts        ),
        .ing_buf_full_drop       ( ing_buf_full_drop       ),
        .egr_buf_full_drop       ( egr_buf_full_drop       ),
        .ing_port_enable         ( ing_port_enable         ),
        .egr_port_enable         ( egr_port_enable         )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #5 core_clk_ifc = ~core_clk_ifc;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    //////////////////////////////
    // Bus access
    //////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge core_clk_ifc);
    endtask

    task automatic bus_write(input int addr, input logic [31:0] data);
        @(posedge core_clk_ifc);
        reg_req <= '{read: 1'b0, write: 1'b1, addr: addr[`ROUTER_REG_ADDR_WIDTH-1:0],
                     wdata: data};
        @(posedge core_clk_ifc);
        reg_req <= '0;
    endtask

    task automatic bus_read(input int addr, output logic [31:0] data, output logic err);
        int waited;
        waited = 0;
        @(posedge core_clk_ifc);
        reg_req <= '{read: 1'b1, write: 1'b0, addr: addr[`ROUTER_REG_ADDR_WIDTH-1:0],
                     wdata: '0};
        @(posedge core_clk_ifc);
        reg_req <= '0;
        // Response is sampled mid-cycle where it is stable
        @(negedge core_clk_ifc);
        while (!reg_rsp.rvalid && waited < RD_LIMIT) begin
            @(negedge core_clk_ifc);
            waited++;
        end
        data = reg_rsp.rdata;
        err  = reg_rsp.error;
        if (!reg_rsp.rvalid) begin
            $display("Read of address %0d timed out with no rvalid after %0d cycles",
                     addr, RD_LIMIT);
            timeout_errs++;
        end else if (waited != 0) begin
            $display("error %0t: read of address %0d gave rvalid %0d cycles late",
                     $time, addr, waited);
            value_errs++;
        end
    endtask

    task automatic read_expect(input int addr, input logic [31:0] exp, input logic exp_err);
        logic [31:0] data;
        logic        err;
        bus_read(addr, data, err);
        check_cnt++;
        if (data !== exp || err !== exp_err) begin
            $display("error %0t: addr %0d read 0x%08h err %0b, expected 0x%08h err %0b",
                     $time, addr, data, err, exp, exp_err);
            value_errs++;
        end
    endtask

    task automatic check_port_enable(input string name, input logic [NP-1:0] got,
                                     input logic [NP-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("error %0t: %s port_enable is 0x%02h, expected 0x%02h",
                     $time, name, got, exp);
            value_errs++;
        end
    endtask

    //////////////////////////////
    // Port stimulus and model
    //////////////////////////////

    task automatic drive_traffic(input int d);
        @(posedge core_clk_ifc);
        for (int p = 0; p < NP; p++) begin
            live_cnts[d][p].pkt_cnt  = lcg_next();
            live_cnts[d][p].byte_cnt = lcg_next();
            live_cnts[d][p].err_cnt  = lcg_next();
            if (d == 0) begin
                ing_traffic_cnts[p] <= live_cnts[d][p];
            end else begin
                egr_traffic_cnts[p] <= live_cnts[d][p];
            end
        end
    endtask

    // One single-cycle drop pulse on each port in the mask, then an idle cycle
    task automatic pulse_drops(input int d, input logic [NP-1:0] mask);
        @(posedge core_clk_ifc);
        if (d == 0) begin
            ing_buf_full_drop <= mask;
        end else begin
            egr_buf_full_drop <= mask;
        end
        @(posedge core_clk_ifc);
        ing_buf_full_drop <= '0;
        egr_buf_full_drop <= '0;
        @(posedge core_clk_ifc);
        for (int p = 0; p < NP; p++) begin
            if (mask[p]) begin
                drop_pend[d][p]++;
            end
        end
    endtask

    task automatic request_sample(input int d, input logic [NP-1:0] mask);
        int con;
        con = (d == 0) ? `ROUTER_ADDR_ING_COUNTER_CON : `ROUTER_ADDR_EGR_COUNTER_CON;
        bus_write(con, 32'd0);
        bus_write(con, 32'(mask));
        // Capture lands two edges after the write
        idle_cycles(2);
        for (int p = 0; p < NP; p++) begin
            if (mask[p]) begin
                snap_exp[d][p]  = live_cnts[d][p];
                drop_exp[d][p]  = drop_pend[d][p];
                drop_pend[d][p] = '0;
            end
        end
    endtask

    task automatic check_snapshots(input int d);
        int base;
        base = (d == 0) ? `ROUTER_ADDR_ING_COUNTERS_START : `ROUTER_ADDR_EGR_COUNTERS_START;
        for (int p = 0; p < NP; p++) begin
            read_expect(base + WPP * p,     snap_exp[d][p].pkt_cnt,  1'b0);
            read_expect(base + WPP * p + 1, snap_exp[d][p].byte_cnt, 1'b0);
            read_expect(base + WPP * p + 2, snap_exp[d][p].err_cnt,  1'b0);
            read_expect(base + WPP * p + 3, drop_exp[d][p],          1'b0);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic verify_reset_values();
        for (int a = 0; a < `ROUTER_TOTAL_REGS; a++) begin
            if (a <= `ROUTER_ADDR_EGR_PORT_ENABLE_STAT) begin
                read_expect(a, PORT_MASK, 1'b0);
            end else begin
                read_expect(a, 32'd0, 1'b0);
            end
        end
        read_expect(`ROUTER_TOTAL_REGS, 32'd0, 1'b1);
        read_expect((1 << `ROUTER_REG_ADDR_WIDTH) - 1, 32'd0, 1'b1);
        check_port_enable("ingress", ing_port_enable, '1);
        check_port_enable("egress", egr_port_enable, '1);
    endtask

    task automatic exercise_port_enables();
        logic [31:0] w;
        int          con;
        int          stat;
        for (int d = 0; d < 2; d++) begin
            con  = (d == 0) ? `ROUTER_ADDR_ING_PORT_ENABLE_CON : `ROUTER_ADDR_EGR_PORT_ENABLE_CON;
            stat = (d == 0) ? `ROUTER_ADDR_ING_PORT_ENABLE_STAT
                            : `ROUTER_ADDR_EGR_PORT_ENABLE_STAT;
            w = lcg_next();
            en_exp[d] = w[NP-1:0];
            bus_write(con, w);
            read_expect(con, w & PORT_MASK, 1'b0);
            read_expect(stat, w & PORT_MASK, 1'b0);
            if (d == 0) begin
                check_port_enable("ingress", ing_port_enable, w[NP-1:0]);
            end else begin
                check_port_enable("egress", egr_port_enable, w[NP-1:0]);
            end
        end
    endtask

    task automatic sample_traffic_snapshots();
        logic [31:0] m;
        for (int d = 0; d < 2; d++) begin
            drive_traffic(d);
            request_sample(d, '1);
            check_snapshots(d);
            // Only masked ports may pick up the new counts
            drive_traffic(d);
            m = lcg_next();
            request_sample(d, m[NP-1:0]);
            check_snapshots(d);
        end
    endtask

    task automatic accumulate_drop_counts();
        logic [NP-1:0] m;
        for (int d = 0; d < 2; d++) begin
            // Round k hits ports k and up, so port p sees p+1 pulses
            for (int k = 0; k < NP; k++) begin
                m = '1;
                pulse_drops(d, m << k);
            end
            request_sample(d, '1);
            check_snapshots(d);
            request_sample(d, '1);
            check_snapshots(d);
        end
    endtask

    task automatic write_read_only_regs();
        int          addrs [6];
        logic [31:0] exp_vals [6];
        addrs = '{`ROUTER_ADDR_ING_PORT_ENABLE_STAT, `ROUTER_ADDR_EGR_PORT_ENABLE_STAT,
                  `ROUTER_ADDR_ING_COUNTERS_START, `ROUTER_ADDR_ING_COUNTERS_START + 5,
                  `ROUTER_ADDR_EGR_COUNTERS_START, `ROUTER_TOTAL_REGS - 1};
        // Port 1 byte word at ingress offset 5, egress port 7 drop word last
        exp_vals = '{32'(en_exp[0]), 32'(en_exp[1]),
                     snap_exp[0][0].pkt_cnt, snap_exp[0][1].byte_cnt,
                     snap_exp[1][0].pkt_cnt, drop_exp[1][NP-1]};
        for (int i = 0; i < 6; i++) begin
            read_expect(addrs[i], exp_vals[i], 1'b0);
            bus_write(addrs[i], lcg_next());
            read_expect(addrs[i], exp_vals[i], 1'b0);
        end
    endtask

    initial begin
        lcg_state               = 32'd32;
        check_cnt               = 0;
        value_errs              = 0;
        timeout_errs            = 0;
        peripheral_sresetn_core = 1'b0;
        reg_req                 = '0;
        ing_buf_full_drop       = '0;
        egr_buf_full_drop       = '0;
        en_exp[0]               = '1;
        en_exp[1]               = '1;
        for (int p = 0; p < NP; p++) begin
            ing_traffic_cnts[p] = '0;
            egr_traffic_cnts[p] = '0;
            for (int d = 0; d < 2; d++) begin
                live_cnts[d][p] = '0;
                snap_exp[d][p]  = '0;
                drop_pend[d][p] = '0;
                drop_exp[d][p]  = '0;
            end
        end
        repeat (16) @(posedge core_clk_ifc);
        peripheral_sresetn_core <= 1'b1;

        verify_reset_values();
        exercise_port_enables();
        sample_traffic_snapshots();
        accumulate_drop_counts();
        write_read_only_regs();
        idle_cycles(2);

        $display("checks %0d, value errors %0d, timeouts %0d",
                 check_cnt, value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
